//--- include/sine_quarter.svh
// first quarter of a sine period, 127 * sin(i * pi / 126)
// entry 63 is the crest so quadrants 0 and 1 mirror cleanly
localparam logic [6:0] SINE_QUARTER [64] = '{
  7'd0,   7'd3,   7'd6,   7'd9,      // 0..3
  7'd13,  7'd16,  7'd19,  7'd22,     // 4..7
  7'd25,  7'd28,  7'd31,  7'd34,     // 8..11
  7'd37,  7'd40,  7'd43,  7'd46,     // 12..15
  7'd49,  7'd52,  7'd55,  7'd58,     // 16..19
  7'd61,  7'd64,  7'd66,  7'd69,     // 20..23
  7'd72,  7'd74,  7'd77,  7'd79,     // 24..27
  7'd82,  7'd84,  7'd86,  7'd89,     // 28..31
  7'd91,  7'd93,  7'd95,  7'd97,     // 32..35
  7'd99,  7'd101, 7'd103, 7'd105,    // 36..39
  7'd107, 7'd108, 7'd110, 7'd112,    // 40..43
  7'd113, 7'd114, 7'd116, 7'd117,    // 44..47
  7'd118, 7'd119, 7'd120, 7'd121,    // 48..51
  7'd122, 7'd123, 7'd124, 7'd124,    // 52..55
  7'd125, 7'd126, 7'd126, 7'd126,    // 56..59
  7'd127, 7'd127, 7'd127, 7'd127     // 60..63
};

//--- verilog/dds_pkg.sv
`default_nettype none

package dds_pkg;

  // datapath widths
  localparam int ACC_BITS    = 32;   // phase accumulator
  localparam int PHASE_BITS  = 8;    // phase word fed to the synthesizer
  localparam int SAMPLE_BITS = 8;    // DAC sample
  localparam int AMP_BITS    = 9;    // 256 is unity gain

  // waveform codes, one per key
  localparam int WAVE_BITS = 2;
  localparam logic [WAVE_BITS-1:0] WAVE_SINE     = 2'd0;   // key 0
  localparam logic [WAVE_BITS-1:0] WAVE_SQUARE   = 2'd1;   // key 1
  localparam logic [WAVE_BITS-1:0] WAVE_TRIANGLE = 2'd2;   // key 2
  localparam logic [WAVE_BITS-1:0] WAVE_SAW      = 2'd3;   // key 3

  // key debounce, 20 us at 50 MHz
  localparam int DEBOUNCE_CYCLES = 1000;
  localparam int DEB_CNT_BITS    = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [DEB_CNT_BITS-1:0] DEB_CNT_MAX = DEB_CNT_BITS'(DEBOUNCE_CYCLES);

  // sine lookup splits the phase into quadrant and table index
  typedef struct packed {
    logic [1:0] quadrant;   // which quarter of the period
    logic [5:0] index;      // position inside the quarter
  } phase_quarter_t;

  // one phase word, read raw or as quadrant/index
  typedef union packed {
    logic [PHASE_BITS-1:0] raw;       // square, triangle, sawtooth
    phase_quarter_t        quarter;   // sine
  } phase_word_u;

endpackage

`default_nettype wire

//--- verilog/key_control.sv
`timescale 1ns/1ps
`default_nettype none

module key_control (
  input  wire                            sys_clk,
  input  wire                            rst,
  input  wire  [3:0]                     key,          // push keys, active low
  output logic [dds_pkg::WAVE_BITS-1:0]  wave_select   // also lights the LEDs
);

  import dds_pkg::*;

  logic [3:0]              key_meta;      // first synchronizer stage
  logic [3:0]              key_sync;      // second synchronizer stage
  logic [3:0]              key_last;      // previous synchronized pattern
  logic [DEB_CNT_BITS-1:0] stable_cnt;    // cycles without a change
  logic                    accepted;      // pattern already acted on
  logic                    stable;
  logic                    press_valid;   // exactly one key down
  logic [WAVE_BITS-1:0]    press_code;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      key_meta <= 4'hf;   // released
      key_sync <= 4'hf;
      key_last <= 4'hf;
    end else begin
      key_meta <= key;
      key_sync <= key_meta;
      key_last <= key_sync;
    end
  end

  assign stable = (stable_cnt == DEB_CNT_MAX);

  // restart on any edge; hold at the limit until the pattern moves
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      stable_cnt <= '0;
      accepted   <= 1'b0;
    end else if (key_sync != key_last) begin
      stable_cnt <= '0;
      accepted   <= 1'b0;
    end else if (!stable) begin
      stable_cnt <= stable_cnt + 1'b1;
    end else begin
      accepted <= 1'b1;   // one shot per stable pattern
    end
  end

  always_comb begin
    press_valid = 1'b1;
    press_code  = WAVE_SINE;
    case (key_sync)
      4'b1110: press_code = WAVE_SINE;
      4'b1101: press_code = WAVE_SQUARE;
      4'b1011: press_code = WAVE_TRIANGLE;
      4'b0111: press_code = WAVE_SAW;
      default: press_valid = 1'b0;   // none or several keys down
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      wave_select <= WAVE_SINE;
    end else if (stable && !accepted && press_valid) begin
      wave_select <= press_code;
    end
  end

endmodule

`default_nettype wire

//--- verilog/phase_accum.sv
`timescale 1ns/1ps
`default_nettype none

module phase_accum (
  input  wire                            sys_clk,
  input  wire                            rst,
  input  wire  [dds_pkg::ACC_BITS-1:0]   freq_ctl,    // phase step per cycle
  input  wire  [dds_pkg::PHASE_BITS-1:0] phase_ctl,   // phase offset
  output dds_pkg::phase_word_u           phase
);

  import dds_pkg::*;

  logic [ACC_BITS-1:0]   acc;       // wraps naturally
  logic [PHASE_BITS-1:0] acc_top;   // coarse phase before offset

  assign acc_top = acc[ACC_BITS-1 -: PHASE_BITS];

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      acc   <= '0;
      phase <= '0;
    end else begin
      acc       <= acc + freq_ctl;
      phase.raw <= acc_top + phase_ctl;   // modulo 256
    end
  end

endmodule

`default_nettype wire

//--- verilog/wave_synth.sv
`timescale 1ns/1ps
`default_nettype none

module wave_synth (
  input  wire                             sys_clk,
  input  wire                             rst,
  input  wire  dds_pkg::phase_word_u      phase,
  input  wire  [dds_pkg::WAVE_BITS-1:0]   wave_select,
  output logic [dds_pkg::SAMPLE_BITS-1:0] sample        // unsigned, mid scale 128
);

  import dds_pkg::*;

  `include "sine_quarter.svh"

  logic [5:0]             sine_idx;     // mirrored in odd quadrants
  logic [6:0]             sine_mag;
  logic [SAMPLE_BITS-1:0] sine_val;
  logic [SAMPLE_BITS-1:0] square_val;
  logic [PHASE_BITS-1:0]  phase_x2;
  logic [SAMPLE_BITS-1:0] tri_val;
  logic [SAMPLE_BITS-1:0] wave_val;

  // 63 - index is the bit inverse of a 6-bit index
  assign sine_idx = phase.quarter.quadrant[0] ? ~phase.quarter.index
                                              : phase.quarter.index;
  assign sine_mag = SINE_QUARTER[sine_idx];

  always_comb begin
    if (phase.quarter.quadrant[1]) begin
      sine_val = 8'd127 - {1'b0, sine_mag};   // lower half period
    end else begin
      sine_val = 8'd128 + {1'b0, sine_mag};
    end
  end

  assign square_val = phase.raw[PHASE_BITS-1] ? 8'd0 : 8'd255;

  // rising ramp, then folded back down
  assign phase_x2 = {phase.raw[PHASE_BITS-2:0], 1'b0};
  assign tri_val  = phase.raw[PHASE_BITS-1] ? ~phase_x2 : phase_x2;

  always_comb begin
    case (wave_select)
      WAVE_SINE:     wave_val = sine_val;
      WAVE_SQUARE:   wave_val = square_val;
      WAVE_TRIANGLE: wave_val = tri_val;
      default:       wave_val = phase.raw;   // sawtooth
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      sample <= '0;
    end else begin
      sample <= wave_val;
    end
  end

endmodule

`default_nettype wire

//--- verilog/amp_scale.sv
`timescale 1ns/1ps
`default_nettype none

module amp_scale (
  input  wire                             sys_clk,
  input  wire                             rst,
  input  wire  [dds_pkg::SAMPLE_BITS-1:0] sample,
  input  wire  [dds_pkg::AMP_BITS-1:0]    amp_ctl,    // 256 passes the sample through
  output logic [dds_pkg::SAMPLE_BITS-1:0] data_out    // toward the DAC
);

  import dds_pkg::*;

  localparam int PROD_BITS = SAMPLE_BITS + AMP_BITS;

  logic [PROD_BITS-1:0]   product;
  logic [SAMPLE_BITS-1:0] scaled;

  assign product = sample * amp_ctl;

  // divide by 256, clip once the product passes full scale
  assign scaled = product[PROD_BITS-1] ? '1
                                       : product[PROD_BITS-2 -: SAMPLE_BITS];

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      data_out <= '0;
    end else begin
      data_out <= scaled;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dds_top.sv
`timescale 1ns/1ps
`default_nettype none

module dds_top (
  input  wire                             sys_clk,       // 50 MHz
  input  wire                             rst,
  input  wire  [3:0]                      key,           // active low
  input  wire  [dds_pkg::ACC_BITS-1:0]    freq_ctl,
  input  wire  [dds_pkg::PHASE_BITS-1:0]  phase_ctl,
  input  wire  [dds_pkg::AMP_BITS-1:0]    amp_ctl,
  output wire  [dds_pkg::SAMPLE_BITS-1:0] data_out,      // DAC sample
  output wire  [dds_pkg::WAVE_BITS-1:0]   wave_select    // LEDs
);

  import dds_pkg::*;

  wire phase_word_u            phase;
  wire [SAMPLE_BITS-1:0]       sample;

  key_control u_key_control (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .key        (key),
    .wave_select(wave_select)
  );

  phase_accum u_phase_accum (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .freq_ctl (freq_ctl),
    .phase_ctl(phase_ctl),
    .phase    (phase)
  );

  wave_synth u_wave_synth (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .phase      (phase),
    .wave_select(wave_select),   // applied one stage after phase
    .sample     (sample)
  );

  amp_scale u_amp_scale (
    .sys_clk (sys_clk),
    .rst     (rst),
    .sample  (sample),
    .amp_ctl (amp_ctl),
    .data_out(data_out)
  );

endmodule

`default_nettype wire

//--- verification/dds_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dds_tb;

  import dds_pkg::*;

  `include "sine_quarter.svh"

  localparam int KEY_TIMEOUT = 3 * DEBOUNCE_CYCLES;

  logic                   sys_clk;
  logic                   rst;
  logic [3:0]             key;          // active low
  logic [ACC_BITS-1:0]    freq_ctl;
  logic [PHASE_BITS-1:0]  phase_ctl;
  logic [AMP_BITS-1:0]    amp_ctl;
  wire  [SAMPLE_BITS-1:0] data_out;
  wire  [WAVE_BITS-1:0]   wave_select;

  // model pipeline, one register per DUT stage
  logic [ACC_BITS-1:0]    m_acc;
  logic [PHASE_BITS-1:0]  m_phase;
  logic [SAMPLE_BITS-1:0] m_sample;
  logic [SAMPLE_BITS-1:0] m_out;
  logic [WAVE_BITS-1:0]   m_wave;
  logic [WAVE_BITS-1:0]   pend_wave;    // code of the key being held
  logic                   pend;

  int errors;
  int test_errors;
  int tests_pass;
  int tests_fail;

  dds_top DUT (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .key        (key),
    .freq_ctl   (freq_ctl),
    .phase_ctl  (phase_ctl),
    .amp_ctl    (amp_ctl),
    .data_out   (data_out),
    .wave_select(wave_select)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;   // 50 MHz
  end

  function automatic logic [SAMPLE_BITS-1:0] sine_ref(input logic [PHASE_BITS-1:0] p);
    int quad;
    int idx;
    int t;
    quad = p / 64;
    idx  = p % 64;
    if (quad == 1 || quad == 3) begin
      t = SINE_QUARTER[63 - idx];   // falling side of each half
    end else begin
      t = SINE_QUARTER[idx];
    end
    if (quad < 2) begin
      return SAMPLE_BITS'(128 + t);
    end
    return SAMPLE_BITS'(127 - t);
  endfunction

  function automatic logic [SAMPLE_BITS-1:0] wave_ref(input logic [PHASE_BITS-1:0] p,
                                                       input logic [WAVE_BITS-1:0] w);
    int d;
    case (w)
      WAVE_SINE:   return sine_ref(p);
      WAVE_SQUARE: return (p < 128) ? 8'd255 : 8'd0;
      WAVE_TRIANGLE: begin
        d = (2 * p) % 256;
        if (p >= 128) begin
          d = 255 - d;   // 8-bit complement
        end
        return SAMPLE_BITS'(d);
      end
      default:     return p;
    endcase
  endfunction

  function automatic logic [SAMPLE_BITS-1:0] scale_ref(input logic [SAMPLE_BITS-1:0] s,
                                                        input logic [AMP_BITS-1:0] a);
    int prod;
    prod = s * a;
    if (prod >= 65536) begin
      return 8'd255;
    end
    return SAMPLE_BITS'(prod / 256);
  endfunction

  function automatic logic [WAVE_BITS-1:0] wave_for_key(input int k);
    case (k)
      0:       return WAVE_SINE;
      1:       return WAVE_SQUARE;
      2:       return WAVE_TRIANGLE;
      default: return WAVE_SAW;
    endcase
  endfunction

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    return lo + ($urandom % (hi - lo + 1));
  endfunction

  function automatic logic [ACC_BITS-1:0] rand_freq();
    if ($urandom % 2 == 0) begin
      return $urandom % 32'h0200_0000;   // slow sweep, many samples per period
    end
    return $urandom;
  endfunction

  task automatic compare_sample(input logic [SAMPLE_BITS-1:0] actual,
                                input logic [SAMPLE_BITS-1:0] expected, input string what);
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
    end
  endtask

  task automatic compare_wave(input logic [WAVE_BITS-1:0] actual,
                              input logic [WAVE_BITS-1:0] expected, input string what);
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
    end
  endtask

  // one clock, model advanced with the inputs the DUT just sampled
  task automatic step();
    @(posedge sys_clk);
    #1;
    m_out    = scale_ref(m_sample, amp_ctl);
    m_sample = wave_ref(m_phase, m_wave);
    m_phase  = PHASE_BITS'((m_acc >> (ACC_BITS - PHASE_BITS)) + phase_ctl);
    m_acc    = m_acc + freq_ctl;
    if (pend && wave_select == pend_wave) begin
      m_wave = pend_wave;   // debounce finished
      pend   = 1'b0;
    end
    compare_wave(wave_select, m_wave, "wave_select");
    compare_sample(data_out, m_out, "data_out");
  endtask

  task automatic run_cycles(input int n, input bit vary_freq);
    repeat (n) begin
      step();
      if (vary_freq) begin
        freq_ctl = rand_freq();
      end
    end
  endtask

  task automatic select_wave(input int k);
    int n;
    key       = ~(4'b0001 << k);
    pend_wave = wave_for_key(k);
    pend      = 1'b1;
    n         = 0;
    while (pend && n < KEY_TIMEOUT) begin
      step();
      freq_ctl = rand_freq();
      n++;
    end
    if (pend) begin
      $display("timeout: key %0d held for %0d cycles but wave_select never changed", k, n);
      errors++;
      test_errors++;
      pend = 1'b0;
    end
    key = 4'hf;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_pass++;
      $display("%s: ok", name);
    end else begin
      tests_fail++;
      $display("%s: FAILED with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int unsigned seed_ret;
    int order[4];
    int j;
    int tmp;
    int k;
    int k2;
    seed_ret    = $urandom(32'h63d0_6b29);
    rst         = 1'b1;
    key         = 4'hf;
    freq_ctl    = '0;
    phase_ctl   = '0;
    amp_ctl     = 9'd256;
    m_acc       = '0;
    m_phase     = '0;
    m_sample    = '0;
    m_out       = '0;
    m_wave      = WAVE_SINE;
    pend_wave   = WAVE_SINE;
    pend        = 1'b0;
    errors      = 0;
    test_errors = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    repeat (10) @(posedge sys_clk);
    #1;
    rst = 1'b0;

    compare_sample(data_out, 8'd0, "data_out after reset");
    compare_wave(wave_select, WAVE_SINE, "wave_select after reset");
    freq_ctl = rand_freq();
    run_cycles(20, 0);
    finish_test("reset state");

    order = '{0, 1, 2, 3};
    for (int i = 3; i > 0; i--) begin   // shuffle key order
      j        = $urandom % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    if (order[0] == 0) begin   // sine is already selected after reset
      order[0] = order[3];
      order[3] = 0;
    end
    for (int i = 0; i < 4; i++) begin
      select_wave(order[i]);
      run_cycles(2000, 1);
    end
    finish_test("key selection");

    for (int i = 0; i < 2; i++) begin
      k   = (int'(m_wave) + 1 + $urandom % 3) % 4;   // a key that would change the wave
      key = ~(4'b0001 << k);
      run_cycles(rand_range(5, DEBOUNCE_CYCLES - 100), 1);
      key = 4'hf;
      run_cycles(DEBOUNCE_CYCLES + 50, 1);
    end
    k   = $urandom % 4;
    k2  = (k + 1 + $urandom % 3) % 4;
    key = ~((4'b0001 << k) | (4'b0001 << k2));   // two keys at once
    run_cycles(2 * DEBOUNCE_CYCLES, 1);
    key = 4'hf;
    run_cycles(DEBOUNCE_CYCLES + 50, 1);
    finish_test("debounce rejection");

    repeat (12) begin
      freq_ctl  = rand_freq();
      phase_ctl = PHASE_BITS'($urandom);
      run_cycles(rand_range(50, 200), 0);
    end
    finish_test("phase and frequency changes");

    for (int w = 0; w < 4; w++) begin
      select_wave(w);
      for (int c = 0; c < 4; c++) begin
        case (c)
          0:       amp_ctl = 9'd0;
          1:       amp_ctl = 9'd256;
          2:       amp_ctl = AMP_BITS'(257 + $urandom % 255);   // saturating
          default: amp_ctl = AMP_BITS'(1 + $urandom % 255);
        endcase
        freq_ctl  = rand_freq();
        phase_ctl = PHASE_BITS'($urandom);
        run_cycles(150, 0);
      end
    end
    finish_test("amplitude scaling");

    $display("tests ok: %0d, tests failing: %0d, mismatches: %0d",
             tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/dds_pkg.sv
verilog/key_control.sv
verilog/phase_accum.sv
verilog/wave_synth.sv
verilog/amp_scale.sv
verilog/dds_top.sv
verification/dds_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the DDS testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dds_tb -f files.f \
  && out="$(./obj_dir/Vdds_tb)" \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx "test passed" \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL"; exit 1; }
